//--- rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [31:0] inst32_t;
    typedef logic [15:0] inst16_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] imm_t;

    // Major opcodes, bits [6:0] of a 32-bit word
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    localparam reg_idx_t REG_ZERO = 5'd0;
    localparam reg_idx_t REG_RA   = 5'd1;
    localparam reg_idx_t REG_SP   = 5'd2;

    // Issue class, one per major opcode
    typedef enum logic [3:0] {
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_FP_LOAD,
        CLS_FP_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_LUI,
        CLS_SYSTEM,
        CLS_INVALID
    } inst_class_t;

endpackage

//--- fetch_pipe_pkg.sv
package fetch_pipe_pkg;

    // One fetch parcel, half of a full-size instruction
    typedef logic [15:0] parcel_t;

    // Aligner state
    typedef enum logic {
        ALIGN_EMPTY,
        ALIGN_HALF_HELD
    } align_state_t;

endpackage

//--- rvc_aligner.sv
`timescale 1ns/10ps

module rvc_aligner #(
    parameter int unsigned     PC_W    = 32,
    parameter logic [PC_W-1:0] BOOT_PC = '0
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    parcel_valid_i,
    input  fetch_pipe_pkg::parcel_t parcel_i,
    input  logic                    redirect_i,
    input  logic [PC_W-1:0]         redirect_pc_i,
    output logic                    al_valid_o,
    output logic [PC_W-1:0]         al_pc_o,
    output rv_isa_pkg::inst32_t     al_inst_o,
    output logic                    al_compressed_o
);

    import fetch_pipe_pkg::*;

    align_state_t    state_q;
    parcel_t         low_half_q;
    logic [PC_W-1:0] pc_q;
    logic            take;
    logic            emit;
    logic            emit_short;

    // Redirect wins over a parcel in the same cycle
    assign take = parcel_valid_i && !redirect_i;

    // Low bits 11 start a 32-bit instruction, anything else is compressed
    assign emit_short = (state_q == ALIGN_EMPTY) && (parcel_i[1:0] != 2'b11);
    assign emit       = take && (emit_short || state_q == ALIGN_HALF_HELD);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= ALIGN_EMPTY;
            pc_q       <= BOOT_PC;
            al_valid_o <= 1'b0;
        end else if (redirect_i) begin
            // Held half is dropped here
            state_q    <= ALIGN_EMPTY;
            pc_q       <= redirect_pc_i;
            al_valid_o <= 1'b0;
        end else begin
            al_valid_o <= emit;
            if (emit) begin
                state_q <= ALIGN_EMPTY;
                pc_q    <= pc_q + (emit_short ? PC_W'(2) : PC_W'(4));
            end else if (take) begin
                state_q <= ALIGN_HALF_HELD;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take && !emit) begin
            low_half_q <= parcel_i;
        end
        if (emit) begin
            al_pc_o         <= pc_q;
            al_compressed_o <= emit_short;
            al_inst_o       <= emit_short ? {16'h0000, parcel_i} : {parcel_i, low_half_q};
        end
    end

endmodule

//--- rvc_expander.sv
`timescale 1ns/10ps

module rvc_expander #(
    parameter int unsigned PC_W = 32
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                in_valid_i,
    input  logic [PC_W-1:0]     in_pc_i,
    input  rv_isa_pkg::inst32_t in_inst_i,
    input  logic                in_compressed_i,
    output logic                ex_valid_o,
    output logic [PC_W-1:0]     ex_pc_o,
    output rv_isa_pkg::inst32_t ex_inst_o,
    output logic                ex_compressed_o
);

    import rv_isa_pkg::*;

    function automatic inst32_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                      reg_idx_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst32_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                      logic [2:0] f3, logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic inst32_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                      logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst32_t enc_b(logic [12:0] off, reg_idx_t rs1, logic [2:0] f3);
        return {off[12], off[10:5], REG_ZERO, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst32_t enc_j(logic [20:0] off, reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    inst16_t     c;
    inst32_t     exp_w;
    reg_idx_t    rd_f;
    reg_idx_t    rs2_f;
    reg_idx_t    rdp;
    reg_idx_t    rs2p;
    logic [11:0] imm6_sx;
    logic [11:0] addi16_imm;
    logic [11:0] addi4_imm;
    logic [11:0] w_off;
    logic [11:0] d_off;
    logic [11:0] wsp_ld_off;
    logic [11:0] wsp_st_off;
    logic [11:0] dsp_ld_off;
    logic [11:0] dsp_st_off;
    logic [20:0] j_off;
    logic [12:0] b_off;

    assign c     = in_inst_i[15:0];
    assign rd_f  = c[11:7];
    assign rs2_f = c[6:2];
    // Primed registers map onto x8..x15
    assign rdp   = {2'b01, c[9:7]};
    assign rs2p  = {2'b01, c[4:2]};

    assign imm6_sx    = {{6{c[12]}}, c[12], c[6:2]};
    assign addi16_imm = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'd0};
    assign addi4_imm  = {2'd0, c[10:7], c[12:11], c[5], c[6], 2'd0};
    assign w_off      = {5'd0, c[5], c[12:10], c[6], 2'd0};
    assign d_off      = {4'd0, c[6:5], c[12:10], 3'd0};
    assign wsp_ld_off = {4'd0, c[3:2], c[12], c[6:4], 2'd0};
    assign wsp_st_off = {4'd0, c[8:7], c[12:9], 2'd0};
    assign dsp_ld_off = {3'd0, c[4:2], c[12], c[6:5], 3'd0};
    assign dsp_st_off = {3'd0, c[9:7], c[12:10], 3'd0};
    assign j_off      = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    assign b_off      = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};

    // Keyed on funct3 and quadrant, unmatched patterns stay zero
    always_comb begin
        exp_w = '0;
        case ({c[15:13], c[1:0]})
            5'b000_00: begin
                if (c[12:5] != 8'd0) begin
                    exp_w = enc_i(addi4_imm, REG_SP, 3'b000, rs2p, OPC_OP_IMM);
                end
            end
            5'b001_00: exp_w = enc_i(d_off, rdp, 3'b011, rs2p, OPC_LOAD_FP);
            5'b010_00: exp_w = enc_i(w_off, rdp, 3'b010, rs2p, OPC_LOAD);
            5'b011_00: exp_w = enc_i(w_off, rdp, 3'b010, rs2p, OPC_LOAD_FP);
            5'b101_00: exp_w = enc_s(d_off, rs2p, rdp, 3'b011, OPC_STORE_FP);
            5'b110_00: exp_w = enc_s(w_off, rs2p, rdp, 3'b010, OPC_STORE);
            5'b111_00: exp_w = enc_s(w_off, rs2p, rdp, 3'b010, OPC_STORE_FP);
            5'b000_01: begin
                // c.nop when rd is x0
                if (rd_f == REG_ZERO) begin
                    exp_w = enc_i(12'd0, REG_ZERO, 3'b000, REG_ZERO, OPC_OP_IMM);
                end else begin
                    exp_w = enc_i(imm6_sx, rd_f, 3'b000, rd_f, OPC_OP_IMM);
                end
            end
            5'b001_01: exp_w = enc_j(j_off, REG_RA);
            5'b010_01: exp_w = enc_i(imm6_sx, REG_ZERO, 3'b000, rd_f, OPC_OP_IMM);
            5'b011_01: begin
                if (rd_f == REG_SP) begin
                    exp_w = enc_i(addi16_imm, REG_SP, 3'b000, REG_SP, OPC_OP_IMM);
                end else if (rd_f != REG_ZERO) begin
                    exp_w = {{14{c[12]}}, c[12], c[6:2], rd_f, OPC_LUI};
                end
            end
            5'b100_01: begin
                case (c[11:10])
                    2'b00: exp_w = enc_i({7'b0000000, c[6:2]}, rdp, 3'b101, rdp, OPC_OP_IMM);
                    2'b01: exp_w = enc_i({7'b0100000, c[6:2]}, rdp, 3'b101, rdp, OPC_OP_IMM);
                    2'b10: exp_w = enc_i(imm6_sx, rdp, 3'b111, rdp, OPC_OP_IMM);
                    default: begin
                        // Bit 12 set is the RV64 word group
                        if (!c[12]) begin
                            case (c[6:5])
                                2'b00: exp_w = enc_r(7'b0100000, rs2p, rdp, 3'b000, rdp);
                                2'b01: exp_w = enc_r(7'b0000000, rs2p, rdp, 3'b100, rdp);
                                2'b10: exp_w = enc_r(7'b0000000, rs2p, rdp, 3'b110, rdp);
                                default: exp_w = enc_r(7'b0000000, rs2p, rdp, 3'b111, rdp);
                            endcase
                        end
                    end
                endcase
            end
            5'b101_01: exp_w = enc_j(j_off, REG_ZERO);
            5'b110_01: exp_w = enc_b(b_off, rdp, 3'b000);
            5'b111_01: exp_w = enc_b(b_off, rdp, 3'b001);
            5'b000_10: exp_w = enc_i({7'b0000000, c[6:2]}, rd_f, 3'b001, rd_f, OPC_OP_IMM);
            5'b001_10: exp_w = enc_i(dsp_ld_off, REG_SP, 3'b011, rd_f, OPC_LOAD_FP);
            5'b010_10: exp_w = enc_i(wsp_ld_off, REG_SP, 3'b010, rd_f, OPC_LOAD);
            5'b011_10: exp_w = enc_i(wsp_ld_off, REG_SP, 3'b010, rd_f, OPC_LOAD_FP);
            5'b100_10: begin
                if (!c[12]) begin
                    // c.jr or c.mv
                    if (rs2_f == REG_ZERO) begin
                        exp_w = enc_i(12'd0, rd_f, 3'b000, REG_ZERO, OPC_JALR);
                    end else begin
                        exp_w = enc_r(7'd0, rs2_f, REG_ZERO, 3'b000, rd_f);
                    end
                end else if (rs2_f != REG_ZERO) begin
                    if (rd_f != REG_ZERO) begin
                        exp_w = enc_r(7'd0, rs2_f, rd_f, 3'b000, rd_f);
                    end
                end else if (rd_f != REG_ZERO) begin
                    exp_w = enc_i(12'd0, rd_f, 3'b000, REG_RA, OPC_JALR);
                end else begin
                    exp_w = enc_i(12'd1, REG_ZERO, 3'b000, REG_ZERO, OPC_SYSTEM);
                end
            end
            5'b101_10: exp_w = enc_s(dsp_st_off, rs2_f, REG_SP, 3'b011, OPC_STORE_FP);
            5'b110_10: exp_w = enc_s(wsp_st_off, rs2_f, REG_SP, 3'b010, OPC_STORE);
            5'b111_10: exp_w = enc_s(wsp_st_off, rs2_f, REG_SP, 3'b010, OPC_STORE_FP);
            default: exp_w = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            ex_pc_o         <= in_pc_i;
            ex_inst_o       <= in_compressed_i ? exp_w : in_inst_i;
            ex_compressed_o <= in_compressed_i;
        end
    end

endmodule

//--- inst_field_decoder.sv
`timescale 1ns/10ps

module inst_field_decoder #(
    parameter int unsigned PC_W = 32
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    in_valid_i,
    input  logic [PC_W-1:0]         in_pc_i,
    input  rv_isa_pkg::inst32_t     in_inst_i,
    input  logic                    in_compressed_i,
    output logic                    out_valid_o,
    output logic [PC_W-1:0]         out_pc_o,
    output rv_isa_pkg::inst32_t     out_inst_o,
    output logic                    out_compressed_o,
    output rv_isa_pkg::inst_class_t out_class_o,
    output rv_isa_pkg::reg_idx_t    out_rd_o,
    output rv_isa_pkg::reg_idx_t    out_rs1_o,
    output rv_isa_pkg::reg_idx_t    out_rs2_o,
    output rv_isa_pkg::imm_t        out_imm_o
);

    import rv_isa_pkg::*;

    inst_class_t cls;
    imm_t        imm;
    imm_t        imm_i;
    imm_t        imm_s;
    imm_t        imm_b;
    imm_t        imm_u;
    imm_t        imm_j;
    logic        use_rd;
    logic        use_rs1;
    logic        use_rs2;

    assign imm_i = {{20{in_inst_i[31]}}, in_inst_i[31:20]};
    assign imm_s = {{20{in_inst_i[31]}}, in_inst_i[31:25], in_inst_i[11:7]};
    assign imm_b = {{19{in_inst_i[31]}}, in_inst_i[31], in_inst_i[7], in_inst_i[30:25],
                    in_inst_i[11:8], 1'b0};
    assign imm_u = {in_inst_i[31:12], 12'd0};
    assign imm_j = {{11{in_inst_i[31]}}, in_inst_i[31], in_inst_i[19:12], in_inst_i[20],
                    in_inst_i[30:21], 1'b0};

    always_comb begin
        case (in_inst_i[6:0])
            OPC_OP:       cls = CLS_ALU_REG;
            OPC_OP_IMM:   cls = CLS_ALU_IMM;
            OPC_LOAD:     cls = CLS_LOAD;
            OPC_LOAD_FP:  cls = CLS_FP_LOAD;
            OPC_STORE:    cls = CLS_STORE;
            OPC_STORE_FP: cls = CLS_FP_STORE;
            OPC_BRANCH:   cls = CLS_BRANCH;
            OPC_JAL:      cls = CLS_JAL;
            OPC_JALR:     cls = CLS_JALR;
            OPC_LUI:      cls = CLS_LUI;
            OPC_SYSTEM:   cls = CLS_SYSTEM;
            default:      cls = CLS_INVALID;
        endcase
    end

    // Fields a class does not encode read as x0
    assign use_rd  = !(cls inside {CLS_STORE, CLS_FP_STORE, CLS_BRANCH, CLS_INVALID});
    assign use_rs1 = !(cls inside {CLS_JAL, CLS_LUI, CLS_INVALID});
    assign use_rs2 = cls inside {CLS_ALU_REG, CLS_STORE, CLS_FP_STORE, CLS_BRANCH};

    always_comb begin
        case (cls)
            CLS_STORE, CLS_FP_STORE: imm = imm_s;
            CLS_BRANCH:              imm = imm_b;
            CLS_JAL:                 imm = imm_j;
            CLS_LUI:                 imm = imm_u;
            CLS_ALU_REG, CLS_INVALID: imm = '0;
            default:                 imm = imm_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            out_pc_o         <= in_pc_i;
            out_inst_o       <= in_inst_i;
            out_compressed_o <= in_compressed_i;
            out_class_o      <= cls;
            out_rd_o         <= use_rd ? in_inst_i[11:7] : REG_ZERO;
            out_rs1_o        <= use_rs1 ? in_inst_i[19:15] : REG_ZERO;
            out_rs2_o        <= use_rs2 ? in_inst_i[24:20] : REG_ZERO;
            out_imm_o        <= imm;
        end
    end

endmodule

//--- rvc_fetch_pipe.sv
`timescale 1ns/10ps

module rvc_fetch_pipe #(
    parameter int unsigned     PC_W    = 32,
    parameter logic [PC_W-1:0] BOOT_PC = '0
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    parcel_valid_i,
    input  fetch_pipe_pkg::parcel_t parcel_i,
    input  logic                    redirect_i,
    input  logic [PC_W-1:0]         redirect_pc_i,
    output logic                    out_valid_o,
    output logic [PC_W-1:0]         out_pc_o,
    output rv_isa_pkg::inst32_t     out_inst_o,
    output logic                    out_compressed_o,
    output rv_isa_pkg::inst_class_t out_class_o,
    output rv_isa_pkg::reg_idx_t    out_rd_o,
    output rv_isa_pkg::reg_idx_t    out_rs1_o,
    output rv_isa_pkg::reg_idx_t    out_rs2_o,
    output rv_isa_pkg::imm_t        out_imm_o
);

    import rv_isa_pkg::*;

    logic            al_valid;
    logic [PC_W-1:0] al_pc;
    inst32_t         al_inst;
    logic            al_compressed;
    logic            ex_valid;
    logic [PC_W-1:0] ex_pc;
    inst32_t         ex_inst;
    logic            ex_compressed;

    rvc_aligner #(
        .PC_W    (PC_W),
        .BOOT_PC (BOOT_PC)
    ) rvc_aligner_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .parcel_valid_i  (parcel_valid_i),
        .parcel_i        (parcel_i),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .al_valid_o      (al_valid),
        .al_pc_o         (al_pc),
        .al_inst_o       (al_inst),
        .al_compressed_o (al_compressed)
    );

    // Redirect also flushes the two later stages
    rvc_expander #(
        .PC_W (PC_W)
    ) rvc_expander_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (redirect_i),
        .in_valid_i      (al_valid),
        .in_pc_i         (al_pc),
        .in_inst_i       (al_inst),
        .in_compressed_i (al_compressed),
        .ex_valid_o      (ex_valid),
        .ex_pc_o         (ex_pc),
        .ex_inst_o       (ex_inst),
        .ex_compressed_o (ex_compressed)
    );

    inst_field_decoder #(
        .PC_W (PC_W)
    ) inst_field_decoder_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (redirect_i),
        .in_valid_i       (ex_valid),
        .in_pc_i          (ex_pc),
        .in_inst_i        (ex_inst),
        .in_compressed_i  (ex_compressed),
        .out_valid_o      (out_valid_o),
        .out_pc_o         (out_pc_o),
        .out_inst_o       (out_inst_o),
        .out_compressed_o (out_compressed_o),
        .out_class_o      (out_class_o),
        .out_rd_o         (out_rd_o),
        .out_rs1_o        (out_rs1_o),
        .out_rs2_o        (out_rs2_o),
        .out_imm_o        (out_imm_o)
    );

endmodule

//--- rvc_fetch_pipe_sva.sv
`timescale 1ns/10ps

module rvc_fetch_pipe_sva #(
    parameter int unsigned PC_W = 32
) (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    redirect_i,
    input logic                    out_valid_i,
    input logic [PC_W-1:0]         out_pc_i,
    input rv_isa_pkg::inst32_t     out_inst_i,
    input logic                    out_compressed_i,
    input rv_isa_pkg::inst_class_t out_class_i
);

    import rv_isa_pkg::*;

    logic [PC_W-1:0] last_pc;
    logic            last_comp;
    logic            have_last;

    // Previous output, forgotten across a redirect
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || redirect_i) begin
            have_last <= 1'b0;
        end else if (out_valid_i) begin
            have_last <= 1'b1;
            last_pc   <= out_pc_i;
            last_comp <= out_compressed_i;
        end
    end

    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i)
        else $error("output valid after a reset cycle");

    redirect_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_i |=> !out_valid_i ##1 !out_valid_i ##1 !out_valid_i)
        else $error("output valid within 3 cycles of a redirect");

    pc_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_i && have_last) |-> out_pc_i == last_pc + (last_comp ? PC_W'(2) : PC_W'(4)))
        else $error("output pc did not step by the previous length");

    zero_invalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_i && out_inst_i == '0) |-> out_class_i == CLS_INVALID)
        else $error("zero word not classed invalid");

endmodule

bind rvc_fetch_pipe rvc_fetch_pipe_sva #(
    .PC_W (PC_W)
) rvc_fetch_pipe_sva_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .redirect_i       (redirect_i),
    .out_valid_i      (out_valid_o),
    .out_pc_i         (out_pc_o),
    .out_inst_i       (out_inst_o),
    .out_compressed_i (out_compressed_o),
    .out_class_i      (out_class_o)
);

//--- tb_rvc_fetch_pipe.sv
`timescale 1ns/10ps

module tb_rvc_fetch_pipe;

    import rv_isa_pkg::*;
    import fetch_pipe_pkg::*;

    localparam int unsigned     PC_W        = 32;
    localparam logic [PC_W-1:0] BOOT_PC     = 32'h0000_1000;
    localparam int              N_LEGAL     = 15;
    localparam int              N_TBL       = 18;
    localparam int              MAX_PARCELS = 150;
    localparam int              TIMEOUT_NS  = (MAX_PARCELS * 8 + 100) * 4;

    typedef struct {
        logic [PC_W-1:0] pc;
        inst32_t         inst;
        logic            comp;
        inst_class_t     cls;
        logic            chk_fields;
        reg_idx_t        rd;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        imm_t            imm;
        int              due;
    } exp_t;

    logic                clk_i;
    logic                rst_n_i;
    logic                parcel_valid_i;
    parcel_t             parcel_i;
    logic                redirect_i;
    logic [PC_W-1:0]     redirect_pc_i;
    logic                out_valid_o;
    logic [PC_W-1:0]     out_pc_o;
    inst32_t             out_inst_o;
    logic                out_compressed_o;
    inst_class_t         out_class_o;
    reg_idx_t            out_rd_o;
    reg_idx_t            out_rs1_o;
    reg_idx_t            out_rs2_o;
    imm_t                out_imm_o;

    parcel_t             tbl_parcel [N_TBL];
    inst32_t             tbl_word [N_TBL];
    inst_class_t         tbl_cls [N_TBL];
    reg_idx_t            tbl_rd [N_TBL];
    reg_idx_t            tbl_rs1 [N_TBL];
    reg_idx_t            tbl_rs2 [N_TBL];
    imm_t                tbl_imm [N_TBL];
    int                  tbl_n;
    exp_t                exp_q [$];
    exp_t                cur;
    logic [PC_W-1:0]     exp_pc;
    int                  cyc;
    int                  errors;
    int                  err_mark;
    int                  tests;
    int                  outputs;

    rvc_fetch_pipe #(
        .PC_W    (PC_W),
        .BOOT_PC (BOOT_PC)
    ) rvc_fetch_pipe_i (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("Timeout: the pipeline stopped producing the expected outputs");
        $display("*** FAILED ***");
        $finish;
    end

    // Class of a 32-bit word from its major opcode
    function automatic inst_class_t class_of(logic [6:0] opc);
        case (opc)
            7'b0110011: return CLS_ALU_REG;
            7'b0010011: return CLS_ALU_IMM;
            7'b0000011: return CLS_LOAD;
            7'b0100011: return CLS_STORE;
            7'b1100011: return CLS_BRANCH;
            7'b1101111: return CLS_JAL;
            7'b0110111: return CLS_LUI;
            7'b1110011: return CLS_SYSTEM;
            default:    return CLS_INVALID;
        endcase
    endfunction

    task automatic add_entry(parcel_t p, inst32_t w, inst_class_t cls,
                             int rd, int rs1, int rs2, int imm);
        tbl_parcel[tbl_n] = p;
        tbl_word[tbl_n]   = w;
        tbl_cls[tbl_n]    = cls;
        tbl_rd[tbl_n]     = reg_idx_t'(rd);
        tbl_rs1[tbl_n]    = reg_idx_t'(rs1);
        tbl_rs2[tbl_n]    = reg_idx_t'(rs2);
        tbl_imm[tbl_n]    = imm_t'(imm);
        tbl_n++;
    endtask

    task automatic load_table();
        tbl_n = 0;
        add_entry(16'h0040, 32'h0041_0413, CLS_ALU_IMM, 8, 2, 0, 4);       // c.addi4spn x8, 4
        add_entry(16'h4144, 32'h0045_2483, CLS_LOAD, 9, 10, 0, 4);         // c.lw x9, 4(x10)
        add_entry(16'h42A2, 32'h0081_2283, CLS_LOAD, 5, 2, 0, 8);          // c.lwsp x5, 8
        add_entry(16'hA822, 32'h0081_3827, CLS_FP_STORE, 0, 2, 8, 16);     // c.fsdsp f8, 16
        add_entry(16'hDC75, 32'hFE04_0EE3, CLS_BRANCH, 0, 8, 0, -4);       // c.beqz x8, -4
        add_entry(16'h2021, 32'h0080_00EF, CLS_JAL, 1, 0, 0, 8);           // c.jal +8
        add_entry(16'h557D, 32'hFFF0_0513, CLS_ALU_IMM, 10, 0, 0, -1);     // c.li x10, -1
        add_entry(16'h6185, 32'h0000_11B7, CLS_LUI, 3, 0, 0, 'h1000);      // c.lui x3, 1
        add_entry(16'h0001, 32'h0000_0013, CLS_ALU_IMM, 0, 0, 0, 0);       // c.nop
        add_entry(16'h929A, 32'h0062_82B3, CLS_ALU_REG, 5, 5, 6, 0);       // c.add x5, x6
        add_entry(16'h8C05, 32'h4094_0433, CLS_ALU_REG, 8, 8, 9, 0);       // c.sub x8, x9
        add_entry(16'h8082, 32'h0000_8067, CLS_JALR, 0, 1, 0, 0);          // c.jr x1
        add_entry(16'h9002, 32'h0010_0073, CLS_SYSTEM, 0, 0, 0, 1);        // c.ebreak
        add_entry(16'hC104, 32'h0095_2023, CLS_STORE, 0, 10, 9, 0);        // c.sw x9, 0(x10)
        add_entry(16'h028E, 32'h0032_9293, CLS_ALU_IMM, 5, 5, 0, 3);       // c.slli x5, 3
        // Illegal ones are all zeros, c.lui with rd x0 and RV64 c.subw
        add_entry(16'h0000, 32'h0, CLS_INVALID, 0, 0, 0, 0);
        add_entry(16'h6001, 32'h0, CLS_INVALID, 0, 0, 0, 0);
        add_entry(16'h9C01, 32'h0, CLS_INVALID, 0, 0, 0, 0);
    endtask

    task automatic drive(parcel_t p);
        parcel_valid_i <= 1'b1;
        parcel_i       <= p;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk_i);
            parcel_valid_i <= 1'b0;
        end
    endtask

    task automatic send_compressed(int idx);
        exp_t e;
        @(posedge clk_i);
        drive(tbl_parcel[idx]);
        e = '{exp_pc, tbl_word[idx], 1'b1, tbl_cls[idx], 1'b1,
              tbl_rd[idx], tbl_rs1[idx], tbl_rs2[idx], tbl_imm[idx], cyc + 4};
        exp_q.push_back(e);
        exp_pc = exp_pc + 2;
    endtask

    task automatic send_word(inst32_t w, int gap);
        exp_t e;
        @(posedge clk_i);
        drive(w[15:0]);
        idle(gap);
        @(posedge clk_i);
        drive(w[31:16]);
        e = '{exp_pc, w, 1'b0, class_of(w[6:0]), 1'b0, 5'd0, 5'd0, 5'd0, 32'd0, cyc + 4};
        exp_q.push_back(e);
        exp_pc = exp_pc + 4;
    endtask

    task automatic drain();
        idle(1);
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        idle(2);
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %-12s done, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    function automatic inst32_t random_word();
        logic [6:0] opcs [9];
        opcs = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011, 7'b1100011,
                 7'b1101111, 7'b0110111, 7'b1110011, 7'b0001011};
        return {25'($urandom), opcs[$urandom % 9]};
    endfunction

    // Each output is compared with the oldest expected entry
    always @(negedge clk_i) begin
        if (rst_n_i && out_valid_o) begin
            assert (exp_q.size() > 0) else begin
                $display("Unexpected output at time %0t for pc %h", $time, out_pc_o);
                errors++;
            end
            if (exp_q.size() > 0) begin
                cur = exp_q.pop_front();
                outputs++;
                assert (cyc == cur.due) else begin
                    $display("FAILED @%0t: latency, pc %h arrived late or early", $time, cur.pc);
                    errors++;
                end
                assert (out_pc_o == cur.pc && out_inst_o == cur.inst) else begin
                    $display("FAILED @%0t: pc/inst got %h/%h exp %h/%h", $time,
                             out_pc_o, out_inst_o, cur.pc, cur.inst);
                    errors++;
                end
                assert (out_compressed_o == cur.comp && out_class_o == cur.cls) else begin
                    $display("FAILED @%0t: pc %h comp/class got %b/%0d exp %b/%0d", $time,
                             cur.pc, out_compressed_o, out_class_o, cur.comp, cur.cls);
                    errors++;
                end
                assert (!cur.chk_fields || (out_rd_o == cur.rd && out_rs1_o == cur.rs1 &&
                        out_rs2_o == cur.rs2)) else begin
                    $display("FAILED @%0t: pc %h fields got %0d,%0d,%0d exp %0d,%0d,%0d",
                             $time, cur.pc, out_rd_o, out_rs1_o, out_rs2_o,
                             cur.rd, cur.rs1, cur.rs2);
                    errors++;
                end
                assert (!cur.chk_fields || out_imm_o == cur.imm) else begin
                    $display("FAILED @%0t: pc %h imm got %h exp %h", $time,
                             cur.pc, out_imm_o, cur.imm);
                    errors++;
                end
            end
        end else if (exp_q.size() > 0) begin
            assert (cyc <= exp_q[0].due) else begin
                $display("Output for pc %h never appeared", exp_q[0].pc);
                errors++;
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        void'($urandom(56953));
        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        parcel_valid_i = 1'b0;
        parcel_i       = '0;
        redirect_i     = 1'b0;
        redirect_pc_i  = '0;
        cyc            = 0;
        errors         = 0;
        err_mark       = 0;
        tests          = 0;
        outputs        = 0;
        exp_pc         = BOOT_PC;
        load_table();
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        idle(2);

        for (int i = 0; i < N_LEGAL; i++) begin
            send_compressed(i);
        end
        drain();
        end_test("expand");

        for (int i = 0; i < 8; i++) begin
            send_word(random_word(), i % 4);
        end
        drain();
        end_test("passthrough");

        for (int i = N_LEGAL; i < N_TBL; i++) begin
            send_compressed(i);
        end
        drain();
        end_test("illegal");

        for (int i = 0; i < 40; i++) begin
            if ($urandom % 2 == 0) begin
                send_compressed($urandom % N_LEGAL);
            end else begin
                send_word(random_word(), $urandom % 3);
            end
            if ($urandom % 4 == 0) begin
                idle(1);
            end
        end
        drain();
        end_test("random_mix");

        // A c.nop in flight and a held low half are both lost
        @(posedge clk_i);
        drive(16'h0001);
        @(posedge clk_i);
        drive(16'h0013);
        @(posedge clk_i);
        parcel_valid_i <= 1'b0;
        redirect_i     <= 1'b1;
        redirect_pc_i  <= 32'h0000_2000;
        @(posedge clk_i);
        redirect_i <= 1'b0;
        exp_pc = 32'h0000_2000;
        send_compressed(9);
        send_word(32'h0062_82B3, 1);
        drain();
        end_test("redirect");

        $display("tests %0d, outputs checked %0d, errors %0d", tests, outputs, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- all.f
rv_isa_pkg.sv
fetch_pipe_pkg.sv
rvc_aligner.sv
rvc_expander.sv
inst_field_decoder.sv
rvc_fetch_pipe.sv
rvc_fetch_pipe_sva.sv
tb_rvc_fetch_pipe.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rvc_fetch_pipe
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
